// ==== design/panel_pkg.sv ====
`default_nettype none

package panel_pkg;

    localparam int PANEL_WIDTH       = 32;
    localparam int PANEL_HALF_HEIGHT = 8;   // row pairs, panel is 16 rows
    localparam int COLOR_PLANES      = 4;
    localparam int SHOW_UNIT         = 8;   // oe cycles of plane 0

    localparam int COL_BITS       = $clog2(PANEL_WIDTH);
    localparam int ROW_BITS       = $clog2(2 * PANEL_HALF_HEIGHT);
    localparam int PAIR_BITS      = $clog2(PANEL_HALF_HEIGHT);
    localparam int PLANE_BITS     = $clog2(COLOR_PLANES);
    localparam int WORD_ADDR_BITS = ROW_BITS + COL_BITS;
    localparam int BYTE_ADDR_BITS = WORD_ADDR_BITS + 1;
    localparam int ROW_BYTES      = 2 * PANEL_WIDTH;
    localparam int BYTE_IDX_BITS  = $clog2(ROW_BYTES);
    localparam int FRAME_WORDS    = PANEL_WIDTH * 2 * PANEL_HALF_HEIGHT;
    localparam int SHOW_BITS      = $clog2(SHOW_UNIT) + COLOR_PLANES;

    // sized end values for the counters
    localparam logic [COL_BITS-1:0]      COL_LAST      = COL_BITS'(PANEL_WIDTH - 1);
    localparam logic [PAIR_BITS-1:0]     PAIR_LAST     = PAIR_BITS'(PANEL_HALF_HEIGHT - 1);
    localparam logic [PLANE_BITS-1:0]    PLANE_LAST    = PLANE_BITS'(COLOR_PLANES - 1);
    localparam logic [BYTE_IDX_BITS-1:0] BYTE_IDX_LAST = BYTE_IDX_BITS'(ROW_BYTES - 1);
    localparam logic [ROW_BITS-1:0]      BOTTOM_OFFSET = ROW_BITS'(PANEL_HALF_HEIGHT);
    localparam logic [SHOW_BITS-1:0]     SHOW_BASE     = SHOW_BITS'(SHOW_UNIT);

    typedef union packed {
        logic [1:0][7:0] as_bytes;                  // [1] is the high byte, sent first
        struct packed {
            logic [15-3*COLOR_PLANES:0] spare;
            logic [COLOR_PLANES-1:0]    red;
            logic [COLOR_PLANES-1:0]    green;
            logic [COLOR_PLANES-1:0]    blue;
        } as_color;
    } pixel_word_u;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

    typedef logic [COLOR_PLANES-1:0] plane_mask_t;  // one enable per bit plane

endpackage

`default_nettype wire

// ==== design/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    localparam int CLKS_PER_BIT = 8;
    localparam int TICK_BITS    = $clog2(CLKS_PER_BIT);

    // sample points inside a bit
    localparam logic [TICK_BITS-1:0] TICK_LAST = TICK_BITS'(CLKS_PER_BIT - 1);
    localparam logic [TICK_BITS-1:0] TICK_HALF = TICK_BITS'(CLKS_PER_BIT / 2 - 1);

    // command bytes
    localparam logic [7:0] CMD_ROW    = 8'h4c;  // 'L'
    localparam logic [7:0] CMD_PLANES = 8'h54;  // 'T'
    localparam logic [7:0] CMD_RGB    = 8'h45;  // 'E'

endpackage

`default_nettype wire

// ==== design/pixel_bus_if.sv ====
`default_nettype none

interface pixel_bus_if;

    logic [panel_pkg::COL_BITS-1:0]   column;
    logic [panel_pkg::PAIR_BITS-1:0]  row;     // row pair, top half index
    logic [panel_pkg::PLANE_BITS-1:0] plane;
    logic                             load;    // one-cycle fetch request
    panel_pkg::rgb_t                  rgb_top;
    panel_pkg::rgb_t                  rgb_bottom;

    modport scan (output column, row, plane, load);

    modport fetch (input column, row, plane, load, output rgb_top, rgb_bottom);

endinterface

`default_nettype wire

// ==== design/uart_rx.sv ====
`default_nettype none

module uart_rx (
    input  wire        clk_in,
    input  wire        rst,
    input  wire        serial_in,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t                      state;
    logic [2:0]                     sync;     // [1] synced line, [2] its last value
    logic [ctrl_pkg::TICK_BITS-1:0] tick;
    logic [2:0]                     bit_idx;
    logic [7:0]                     shift;
    logic                           line;

    assign line = sync[1];

    always_ff @(posedge clk_in) begin
        if (rst) begin
            sync <= '1;  // idle line is high
        end else begin
            sync <= {sync[1:0], serial_in};
        end
    end

    always_ff @(posedge clk_in) begin
        rx_valid <= 1'b0;
        if (rst) begin
            state   <= IDLE;
            tick    <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (sync[2] && !line) begin  // falling start edge
                        state <= START;
                        tick  <= '0;
                    end
                end
                START: begin
                    if (tick == ctrl_pkg::TICK_HALF) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= line ? IDLE : DATA;  // glitch, not a start bit
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                DATA: begin
                    if (tick == ctrl_pkg::TICK_LAST) begin
                        tick    <= '0;
                        shift   <= {line, shift[7:1]};  // lsb first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                STOP: begin
                    if (tick == ctrl_pkg::TICK_LAST) begin
                        state <= IDLE;
                        if (line) begin  // framing error drops the byte
                            rx_valid <= 1'b1;
                            rx_data  <= shift;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_loader.sv ====
`default_nettype none

module frame_loader (
    input  wire                                     clk_in,
    input  wire                                     rst,
    input  wire  [7:0]                              rx_data,
    input  wire                                     rx_valid,
    output logic                                    wr_en,
    output logic [panel_pkg::BYTE_ADDR_BITS-1:0]    wr_addr,
    output logic [7:0]                              wr_data,
    output panel_pkg::plane_mask_t                  plane_enable,
    output panel_pkg::rgb_t                         rgb_enable
);

    typedef enum logic [2:0] {
        IDLE,
        PLANES_ARG,
        RGB_ARG,
        ROW_SEL,
        ROW_DATA
    } load_state_t;

    load_state_t                           state;
    logic [panel_pkg::ROW_BITS-1:0]        row;
    logic [panel_pkg::BYTE_IDX_BITS-1:0]   byte_idx;

    always_ff @(posedge clk_in) begin
        wr_en <= 1'b0;
        if (rst) begin
            state        <= IDLE;
            plane_enable <= '1;
            rgb_enable   <= '1;
        end else if (rx_valid) begin
            case (state)
                IDLE: begin
                    case (rx_data)
                        ctrl_pkg::CMD_ROW:    state <= ROW_SEL;
                        ctrl_pkg::CMD_PLANES: state <= PLANES_ARG;
                        ctrl_pkg::CMD_RGB:    state <= RGB_ARG;
                        default:              state <= IDLE;  // unknown byte
                    endcase
                end
                PLANES_ARG: begin
                    plane_enable <= rx_data[panel_pkg::COLOR_PLANES-1:0];
                    state        <= IDLE;
                end
                RGB_ARG: begin
                    rgb_enable <= rx_data[2:0];  // bit 2 red, bit 0 blue
                    state      <= IDLE;
                end
                ROW_SEL: begin
                    row      <= rx_data[panel_pkg::ROW_BITS-1:0];
                    byte_idx <= '0;
                    state    <= ROW_DATA;
                end
                ROW_DATA: begin
                    wr_en    <= 1'b1;
                    wr_addr  <= {row, byte_idx};  // row * ROW_BYTES + index
                    wr_data  <= rx_data;
                    byte_idx <= byte_idx + 1'b1;
                    if (byte_idx == panel_pkg::BYTE_IDX_LAST) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_buffer.sv ====
`default_nettype none

module frame_buffer (
    input  wire                                   clk_in,
    input  wire                                   wr_en,
    input  wire  [panel_pkg::BYTE_ADDR_BITS-1:0]  wr_addr,
    input  wire  [7:0]                            wr_data,
    input  wire                                   rd_en,
    input  wire  [panel_pkg::WORD_ADDR_BITS-1:0]  rd_addr,
    output panel_pkg::pixel_word_u                rd_data
);

    panel_pkg::pixel_word_u mem [panel_pkg::FRAME_WORDS];

    initial begin
        for (int i = 0; i < panel_pkg::FRAME_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // byte port, even address lands in the high byte
    always @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr[panel_pkg::BYTE_ADDR_BITS-1:1]].as_bytes[~wr_addr[0]] <= wr_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/matrix_scan.sv ====
`default_nettype none

module matrix_scan (
    input  wire                               clk_in,
    input  wire                               rst,
    pixel_bus_if.scan                         bus,
    output logic                              clk_pixel,
    output logic                              row_latch,
    output logic                              oe_n,
    output logic [panel_pkg::PAIR_BITS-1:0]   row_address
);

    typedef enum logic [1:0] {SHIFT, LATCH, SHOW} scan_state_t;

    scan_state_t                          state;
    logic [1:0]                           phase;     // four clocks per column
    logic [panel_pkg::COL_BITS-1:0]       column;
    logic [panel_pkg::PLANE_BITS-1:0]     plane;
    logic [panel_pkg::PAIR_BITS-1:0]      row;
    logic [panel_pkg::SHOW_BITS-1:0]      show_cnt;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state       <= SHIFT;
            phase       <= '0;
            column      <= '0;
            plane       <= '0;
            row         <= '0;
            row_address <= '0;
            show_cnt    <= '0;
        end else begin
            case (state)
                SHIFT: begin
                    phase <= phase + 1'b1;
                    if (phase == 2'd3) begin
                        if (column == panel_pkg::COL_LAST) begin
                            column <= '0;
                            state  <= LATCH;
                        end else begin
                            column <= column + 1'b1;
                        end
                    end
                end
                LATCH: begin
                    row_address <= row;  // held through the whole show
                    // binary weight, plane p shows SHOW_UNIT << p cycles
                    show_cnt    <= (panel_pkg::SHOW_BASE << plane) - 1'b1;
                    state       <= SHOW;
                end
                SHOW: begin
                    if (show_cnt == '0) begin
                        state <= SHIFT;
                        if (plane == panel_pkg::PLANE_LAST) begin
                            plane <= '0;
                            row   <= (row == panel_pkg::PAIR_LAST) ? '0 : row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        show_cnt <= show_cnt - 1'b1;
                    end
                end
                default: state <= SHIFT;
            endcase
        end
    end

    // panel strobes decoded from the state
    assign bus.load  = (state == SHIFT) && (phase == 2'd0);
    assign clk_pixel = (state == SHIFT) && (phase == 2'd3);  // data settled by now
    assign row_latch = (state == LATCH);
    assign oe_n      = (state != SHOW);

    assign bus.column = column;
    assign bus.row    = row;
    assign bus.plane  = plane;

endmodule

`default_nettype wire

// ==== design/pixel_fetch.sv ====
`default_nettype none

module pixel_fetch (
    input  wire                                   clk_in,
    input  wire                                   rst,
    pixel_bus_if.fetch                            bus,
    input  wire  panel_pkg::plane_mask_t          plane_enable,
    input  wire  panel_pkg::rgb_t                 rgb_enable,
    output logic                                  rd_en,
    output logic [panel_pkg::WORD_ADDR_BITS-1:0]  rd_addr,
    input  wire  panel_pkg::pixel_word_u          rd_data
);

    logic                               load_d1;   // top word on rd_data
    logic                               load_d2;   // bottom word on rd_data
    logic [panel_pkg::COL_BITS-1:0]     col_q;
    logic [panel_pkg::PAIR_BITS-1:0]    row_q;
    logic [panel_pkg::PLANE_BITS-1:0]   plane_q;
    logic [panel_pkg::ROW_BITS-1:0]     bottom_row;
    panel_pkg::rgb_t                    top_q;

    // one plane bit per channel, gated by both masks
    function automatic panel_pkg::rgb_t plane_bits(
        input panel_pkg::pixel_word_u        word,
        input logic [panel_pkg::PLANE_BITS-1:0] p,
        input panel_pkg::plane_mask_t        pmask,
        input panel_pkg::rgb_t               cmask
    );
        panel_pkg::rgb_t bits;
        bits.red   = word.as_color.red[p]   & pmask[p] & cmask.red;
        bits.green = word.as_color.green[p] & pmask[p] & cmask.green;
        bits.blue  = word.as_color.blue[p]  & pmask[p] & cmask.blue;
        return bits;
    endfunction

    assign bottom_row = {1'b0, row_q} + panel_pkg::BOTTOM_OFFSET;

    // top read straight off the load, bottom read one cycle later
    assign rd_en   = bus.load | load_d1;
    assign rd_addr = bus.load ? {1'b0, bus.row, bus.column} : {bottom_row, col_q};

    always_ff @(posedge clk_in) begin
        if (rst) begin
            load_d1 <= 1'b0;
            load_d2 <= 1'b0;
        end else begin
            load_d1 <= bus.load;
            load_d2 <= load_d1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (bus.load) begin
            col_q   <= bus.column;
            row_q   <= bus.row;
            plane_q <= bus.plane;
        end
        if (load_d1) begin
            top_q <= plane_bits(rd_data, plane_q, plane_enable, rgb_enable);
        end
    end

    // both halves change together, three cycles after load
    always_ff @(posedge clk_in) begin
        if (rst) begin
            bus.rgb_top    <= '0;
            bus.rgb_bottom <= '0;
        end else if (load_d2) begin
            bus.rgb_top    <= top_q;
            bus.rgb_bottom <= plane_bits(rd_data, plane_q, plane_enable, rgb_enable);
        end
    end

endmodule

`default_nettype wire

// ==== design/led_matrix_top.sv ====
`default_nettype none

module led_matrix_top (
    input  wire                              clk_in,
    input  wire                              rst,
    input  wire                              uart_rx_in,
    output panel_pkg::rgb_t                  rgb_top,
    output panel_pkg::rgb_t                  rgb_bottom,
    output logic [panel_pkg::PAIR_BITS-1:0]  row_address,
    output logic                             clk_pixel,
    output logic                             row_latch,
    output logic                             oe_n      // active low
);

    logic [7:0]                            rx_data;
    logic                                  rx_valid;
    logic                                  wr_en;
    logic [panel_pkg::BYTE_ADDR_BITS-1:0]  wr_addr;
    logic [7:0]                            wr_data;
    panel_pkg::plane_mask_t                plane_enable;
    panel_pkg::rgb_t                       rgb_enable;
    logic                                  rd_en;
    logic [panel_pkg::WORD_ADDR_BITS-1:0]  rd_addr;
    panel_pkg::pixel_word_u                rd_data;

    pixel_bus_if pix_bus ();

    uart_rx rx_uart (
        .clk_in    (clk_in),
        .rst       (rst),
        .serial_in (uart_rx_in),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid)
    );

    frame_loader loader (
        .clk_in       (clk_in),
        .rst          (rst),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .plane_enable (plane_enable),
        .rgb_enable   (rgb_enable)
    );

    frame_buffer fb (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    matrix_scan scan (
        .clk_in      (clk_in),
        .rst         (rst),
        .bus         (pix_bus.scan),
        .clk_pixel   (clk_pixel),
        .row_latch   (row_latch),
        .oe_n        (oe_n),
        .row_address (row_address)
    );

    pixel_fetch fetch (
        .clk_in       (clk_in),
        .rst          (rst),
        .bus          (pix_bus.fetch),
        .plane_enable (plane_enable),
        .rgb_enable   (rgb_enable),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    // panel data pins
    assign rgb_top    = pix_bus.rgb_top;
    assign rgb_bottom = pix_bus.rgb_bottom;

endmodule

`default_nettype wire

// ==== tb/led_matrix_props.sv ====
`default_nettype none

module led_matrix_props (
    input wire                             clk_in,
    input wire                             rst,
    input wire                             clk_pixel,
    input wire                             row_latch,
    input wire                             oe_n,
    input wire [panel_pkg::PAIR_BITS-1:0]  row_address
);
    timeunit 1ns;
    timeprecision 100ps;

    // latch and display never overlap
    no_latch_during_show: assert property (
        @(posedge clk_in) disable iff (rst) !(row_latch && !oe_n)
    ) else $error("row_latch high while oe_n is low");

    no_pixel_clock_at_latch: assert property (
        @(posedge clk_in) disable iff (rst) row_latch |-> !clk_pixel
    ) else $error("clk_pixel high while row_latch is high");

    // row select held for the whole show
    row_stable_during_show: assert property (
        @(posedge clk_in) disable iff (rst) (!oe_n && !$past(oe_n)) |-> $stable(row_address)
    ) else $error("row_address changed while oe_n stayed low");

endmodule

bind matrix_scan led_matrix_props props (
    .clk_in      (clk_in),
    .rst         (rst),
    .clk_pixel   (clk_pixel),
    .row_latch   (row_latch),
    .oe_n        (oe_n),
    .row_address (row_address)
);

`default_nettype wire

// ==== tb/led_matrix_tb.sv ====
`default_nettype none

module led_matrix_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SHOW_TIMEOUT = 1000;  // more cycles than one full plane takes
    localparam int FRAME_PLANES = panel_pkg::PANEL_HALF_HEIGHT * panel_pkg::COLOR_PLANES;
    localparam int WIDTH        = panel_pkg::PANEL_WIDTH;

    logic                            clk_in;
    logic                            rst;
    logic                            uart_rx_in;
    panel_pkg::rgb_t                 rgb_top;
    panel_pkg::rgb_t                 rgb_bottom;
    logic [panel_pkg::PAIR_BITS-1:0] row_address;
    logic                            clk_pixel;
    logic                            row_latch;
    logic                            oe_n;

    // reference model of the frame and masks
    logic [15:0]                        model_words [panel_pkg::FRAME_WORDS];
    logic [panel_pkg::COLOR_PLANES-1:0] model_planes;
    logic [2:0]                         model_rgb;  // red, green, blue
    logic [31:0]                        rng_state;

    // panel monitor
    logic [2:0] shift_top [WIDTH];
    logic [2:0] shift_bot [WIDTH];
    logic [2:0] rec_top [WIDTH];
    logic [2:0] rec_bot [WIDTH];
    int         col_cnt;
    int         low_cnt;
    int         exp_plane;
    int         exp_pair;
    int         rec_pulses;
    int         rec_len;
    int         rec_row;
    int         rec_plane;
    int         rec_pair;
    int         shows_done;

    led_matrix_top dut (
        .clk_in      (clk_in),
        .rst         (rst),
        .uart_rx_in  (uart_rx_in),
        .rgb_top     (rgb_top),
        .rgb_bottom  (rgb_bottom),
        .row_address (row_address),
        .clk_pixel   (clk_pixel),
        .row_latch   (row_latch),
        .oe_n        (oe_n)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // samples the panel pins in the middle of each clock
    always @(negedge clk_in) begin
        if (rst) begin
            col_cnt    = 0;
            low_cnt    = 0;
            exp_plane  = 0;
            exp_pair   = 0;
            shows_done = 0;
        end else begin
            if (clk_pixel) begin
                if (col_cnt < WIDTH) begin
                    shift_top[col_cnt] = rgb_top;
                    shift_bot[col_cnt] = rgb_bottom;
                end
                col_cnt++;
            end
            if (row_latch) begin
                rec_top    = shift_top;
                rec_bot    = shift_bot;
                rec_pulses = col_cnt;
                rec_plane  = exp_plane;
                rec_pair   = exp_pair;
                col_cnt    = 0;
            end
            if (!oe_n) begin
                if (low_cnt == 0) begin
                    rec_row = int'(row_address);  // row that follows the latch
                end
                low_cnt++;
            end else if (low_cnt != 0) begin
                rec_len = low_cnt;
                low_cnt = 0;
                shows_done++;
                if (exp_plane == panel_pkg::COLOR_PLANES - 1) begin
                    exp_plane = 0;
                    exp_pair  = (exp_pair + 1) % panel_pkg::PANEL_HALF_HEIGHT;
                end else begin
                    exp_plane++;
                end
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] next_random_byte();
        rng_state = xorshift(rng_state);
        return rng_state[7:0];
    endfunction

    // plane bit of each channel gated by the model masks
    function automatic logic [2:0] expect_bits(input logic [15:0] word, input int p);
        logic [2:0] bits;
        bits = {word[8 + p], word[4 + p], word[p]};
        return bits & {3{model_planes[p]}} & model_rgb;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic drive_bit(input logic b);
        uart_rx_in = b;
        repeat (ctrl_pkg::CLKS_PER_BIT) @(posedge clk_in);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] b);
        drive_bit(1'b0);  // start
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(1'b1);  // stop
        drive_bit(1'b1);  // idle gap
    endtask

    task automatic write_row(input int row);
        logic [7:0] b;
        int         idx;
        send_byte(ctrl_pkg::CMD_ROW);
        send_byte(8'(row));
        for (int i = 0; i < panel_pkg::ROW_BYTES; i++) begin
            b   = next_random_byte();
            idx = row * WIDTH + i / 2;
            if (i % 2 == 0) begin
                model_words[idx][15:8] = b;  // high byte first
            end else begin
                model_words[idx][7:0] = b;
            end
            send_byte(b);
        end
    endtask

    // wait for the end of the next oe_n low period
    task automatic next_show();
        int start;
        int waited;
        start  = shows_done;
        waited = 0;
        while (shows_done == start && waited < SHOW_TIMEOUT) begin
            @(posedge clk_in);
            waited++;
        end
        if (shows_done == start) begin
            $display("timeout: no complete plane display within %0d cycles", SHOW_TIMEOUT);
            $display("ERRORS FOUND");
            $fatal(1, "panel scan stalled");
        end
        #1;
    endtask

    task automatic check_plane();
        int top_base;
        int bot_base;
        top_base = rec_pair * WIDTH;
        bot_base = (rec_pair + panel_pkg::PANEL_HALF_HEIGHT) * WIDTH;
        check_value("clk_pixel pulses", rec_pulses, WIDTH);
        check_value("oe_n low cycles", rec_len, panel_pkg::SHOW_UNIT << rec_plane);
        check_value("row_address", rec_row, rec_pair);
        for (int c = 0; c < WIDTH; c++) begin
            check_value($sformatf("rgb_top col %0d plane %0d", c, rec_plane),
                        32'(rec_top[c]), 32'(expect_bits(model_words[top_base + c], rec_plane)));
            check_value($sformatf("rgb_bottom col %0d plane %0d", c, rec_plane),
                        32'(rec_bot[c]), 32'(expect_bits(model_words[bot_base + c], rec_plane)));
        end
    endtask

    task automatic check_planes(input int count);
        for (int n = 0; n < count; n++) begin
            next_show();
            check_plane();
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk_in);
        check_value("oe_n", 32'(oe_n), 1);
        check_value("clk_pixel", 32'(clk_pixel), 0);
        check_value("row_latch", 32'(row_latch), 0);
        check_planes(panel_pkg::COLOR_PLANES);  // row pair 0 from a clear frame
    endtask

    task automatic test_row_write();
        write_row(5);
        write_row(13);  // bottom half of the same pair
        next_show();    // plane in flight during the writes
        check_planes(FRAME_PLANES);
    endtask

    task automatic test_plane_mask();
        send_byte(ctrl_pkg::CMD_PLANES);
        send_byte(8'h05);
        model_planes = 4'b0101;
        next_show();
        check_planes(FRAME_PLANES);
    endtask

    task automatic test_rgb_mask();
        send_byte(8'h00);  // unknown
        send_byte(ctrl_pkg::CMD_PLANES);
        send_byte(8'h0f);
        model_planes = 4'b1111;
        send_byte(8'h3c);  // unknown
        send_byte(ctrl_pkg::CMD_RGB);
        send_byte(8'h05);  // green off
        model_rgb = 3'b101;
        send_byte(8'ha2);  // unknown
        next_show();
        check_planes(FRAME_PLANES);
    endtask

    initial begin
        rst          = 1'b1;
        uart_rx_in   = 1'b1;
        rng_state    = 32'h88a4;
        model_planes = '1;
        model_rgb    = '1;
        for (int i = 0; i < panel_pkg::FRAME_WORDS; i++) begin
            model_words[i] = '0;
        end
        repeat (8) @(posedge clk_in);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_row_write();
        test_plane_mask();
        test_rgb_mask();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/panel_pkg.sv
design/ctrl_pkg.sv
design/pixel_bus_if.sv
design/uart_rx.sv
design/frame_loader.sv
design/frame_buffer.sv
design/matrix_scan.sv
design/pixel_fetch.sv
design/led_matrix_top.sv
tb/led_matrix_props.sv
tb/led_matrix_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= led_matrix_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "ERRORS FOUND" >> $(LOG)
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
